// File: logic/bpred_pkg.sv
/* Branch prediction shared definitions
   Table sizes, reset PC and the PC field view used by the BTB */
package bpred_pkg;

	// BTB geometry
	localparam int btb_rows = 16;		// Direct mapped rows
	localparam int btb_index_bits = 4;	// PC[5:2]
	localparam int btb_tag_bits = 10;	// PC[15:6]
	localparam int btb_target_bits = 12;	// Stored target is PC[13:2]

	// Direction table geometry
	localparam int bht_rows = 64;		// Two-bit counters
	localparam int bht_index_bits = 6;	// PC[7:2]

	// Weakly not taken, upper bit is the prediction
	localparam logic [1:0] ctr_reset = 2'b01;

	// First fetch address out of reset
	localparam logic [31:0] reset_pc = 32'h0000_1000;

	// Width left over above the tag
	localparam int pc_high_bits = 32 - btb_tag_bits - btb_index_bits - 2;

	// PC word, either raw or split into BTB fields
	typedef union packed {
		logic [31:0] word;			// Raw address
		struct packed {
			logic [pc_high_bits-1:0] high;		// Above the tag, PC[31:16]
			logic [btb_tag_bits-1:0] tag;		// PC[15:6]
			logic [btb_index_bits-1:0] index;	// PC[5:2]
			logic [1:0] offset;			// Byte offset, zero for aligned fetch
		} f;
	} pc_word_u;

endpackage

// File: logic/btb.sv
/* Direct-mapped branch target buffer with partial targets
   Combinational lookup with the pending update bypassed in, allocate on taken */
`timescale 1ns/1ps

module btb (
	input logic clock,
	input logic reset,
	input bpred_pkg::pc_word_u lookup_pc,		// Fetch address
	input logic lookup_en,				// Fetched word is a branch
	input logic update_en,				// Taken branch resolved
	input bpred_pkg::pc_word_u update_pc,		// Address of the resolved branch
	input logic [31:0] update_target,		// Its computed target
	output logic hit,
	output logic [31:0] target
);

	import bpred_pkg::*;

	// Table state
	logic [btb_rows-1:0] valid;
	logic [btb_rows-1:0] next_valid;
	logic [btb_rows-1:0][btb_tag_bits-1:0] tag;
	logic [btb_rows-1:0][btb_tag_bits-1:0] next_tag;
	logic [btb_rows-1:0][btb_target_bits-1:0] target_addr;	// PC[13:2] of the target
	logic [btb_rows-1:0][btb_target_bits-1:0] next_target_addr;

	// Row selects
	logic [btb_index_bits-1:0] lookup_index;
	logic [btb_index_bits-1:0] update_index;
	logic tag_match;

	assign lookup_index = lookup_pc.f.index;
	assign update_index = update_pc.f.index;

	// Next state of the table
	always_comb begin
		next_valid = valid;
		next_tag = tag;
		next_target_addr = target_addr;
		// A taken branch claims its row whatever was there before
		if (update_en) begin
			next_valid[update_index] = 1'b1;
			next_tag[update_index] = update_pc.f.tag;
			next_target_addr[update_index] = update_target[btb_target_bits+1:2];
		end
	end

	// Lookup sees this cycle's update
	assign tag_match = (next_tag[lookup_index] == lookup_pc.f.tag);

	always_comb begin
		hit = lookup_en & next_valid[lookup_index] & tag_match;
		if (hit) begin
			// Upper bits come from the fetch PC and the low two bits are zero
			target = {lookup_pc.word[31:btb_target_bits+2],
				next_target_addr[lookup_index], 2'b00};
		end else begin
			target = lookup_pc.word;	// Falls back to the fetch PC
		end
	end

	// Valid bits clear on reset
	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else begin
			valid <= next_valid;
		end
	end

	// Tag and target arrays
	always_ff @(posedge clock) begin
		tag <= next_tag;
		target_addr <= next_target_addr;
	end

endmodule

// File: logic/bht.sv
/* Branch history table of two-bit saturating direction counters
   Combinational lookup with this cycle's training bypassed in */
`timescale 1ns/1ps

module bht (
	input logic clock,
	input logic reset,
	input logic [31:0] lookup_pc,		// Fetch address
	input logic update_en,			// Branch resolved this cycle
	input logic [31:0] update_pc,		// Address of the resolved branch
	input logic update_taken,		// Its outcome
	output logic taken			// Predicted direction at lookup_pc
);

	import bpred_pkg::*;

	logic [bht_rows-1:0][1:0] ctr;
	logic [bht_rows-1:0][1:0] next_ctr;
	logic [bht_index_bits-1:0] lookup_index;	// PC[7:2]
	logic [bht_index_bits-1:0] update_index;
	logic [1:0] cur_ctr;				// Counter being trained
	logic [1:0] trained_ctr;

	assign lookup_index = lookup_pc[bht_index_bits+1:2];
	assign update_index = update_pc[bht_index_bits+1:2];
	assign cur_ctr = ctr[update_index];

	// Saturating step, stops at 0 and 3
	always_comb begin
		trained_ctr = cur_ctr;
		if (update_taken) begin
			if (cur_ctr != 2'b11)
				trained_ctr = cur_ctr + 2'b01;
		end else begin
			if (cur_ctr != 2'b00)
				trained_ctr = cur_ctr - 2'b01;
		end
	end

	always_comb begin
		next_ctr = ctr;
		if (update_en)
			next_ctr[update_index] = trained_ctr;
	end

	// Upper bit of the bypassed counter
	assign taken = next_ctr[lookup_index][1];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < bht_rows; i++) begin
				ctr[i] <= ctr_reset;	// Weakly not taken
			end
		end else begin
			ctr <= next_ctr;
		end
	end

endmodule

// File: logic/fetch_pc_gen.sv
/* Fetch address generator
   Picks redirect, stall, predicted target or next sequential PC each cycle */
`timescale 1ns/1ps

module fetch_pc_gen (
	input logic clock,
	input logic reset,
	input logic fetch_ready,		// Low holds the PC
	input logic predict_taken,		// Predictor says jump
	input logic [31:0] predict_target,
	input logic redirect,			// Execute found a misprediction
	input logic [31:0] resolve_pc,
	input logic resolve_taken,
	input logic [31:0] resolve_target,
	output logic [31:0] fetch_pc
);

	import bpred_pkg::*;

	logic [31:0] seq_pc;		// Fall-through address
	logic [31:0] redirect_pc;	// Corrected address from execute
	logic [31:0] next_pc;

	assign seq_pc = fetch_pc + 32'd4;

	// Taken branch goes to its target, otherwise to the word after it
	assign redirect_pc = resolve_taken ? resolve_target : resolve_pc + 32'd4;

	// Priority below reset
	always_comb begin
		if (redirect) begin
			next_pc = redirect_pc;		// Wins over a stall too
		end else if (!fetch_ready) begin
			next_pc = fetch_pc;		// Stalled
		end else if (predict_taken) begin
			next_pc = predict_target;
		end else begin
			next_pc = seq_pc;
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			fetch_pc <= reset_pc;
		else
			fetch_pc <= next_pc;
	end

endmodule

// File: logic/branch_predictor.sv
/* Fetch-side branch predictor
   BTB plus direction counters feeding the fetch PC generator */
`timescale 1ns/1ps

module branch_predictor (
	input logic clock,
	input logic reset,
	input logic fetch_ready,		// Fetch can accept a new PC
	input logic fetch_is_branch,		// Decode flag for the word at fetch_pc
	input logic resolve_valid,		// Execute reports a branch
	input logic [31:0] resolve_pc,
	input logic resolve_taken,
	input logic [31:0] resolve_target,
	input logic resolve_mispredict,
	output logic [31:0] fetch_pc,
	output logic predict_taken,
	output logic [31:0] predict_target
);

	logic btb_hit;
	logic [31:0] btb_target;
	logic dir_taken;		// Counter says taken
	logic btb_alloc;		// Only taken branches go in the BTB
	logic redirect;

	assign btb_alloc = resolve_valid & resolve_taken;
	assign redirect = resolve_valid & resolve_mispredict;

	// Needs a known target and a taken direction
	assign predict_taken = btb_hit & dir_taken;
	assign predict_target = btb_target;

	btb btb_i (
		.clock(clock),
		.reset(reset),
		.lookup_pc(fetch_pc),
		.lookup_en(fetch_is_branch),
		.update_en(btb_alloc),
		.update_pc(resolve_pc),
		.update_target(resolve_target),
		.hit(btb_hit),
		.target(btb_target)
	);

	bht bht_i (
		.clock(clock),
		.reset(reset),
		.lookup_pc(fetch_pc),
		.update_en(resolve_valid),	// Trains on every outcome
		.update_pc(resolve_pc),
		.update_taken(resolve_taken),
		.taken(dir_taken)
	);

	fetch_pc_gen pc_gen_i (
		.clock(clock),
		.reset(reset),
		.fetch_ready(fetch_ready),
		.predict_taken(predict_taken),
		.predict_target(predict_target),
		.redirect(redirect),
		.resolve_pc(resolve_pc),
		.resolve_taken(resolve_taken),
		.resolve_target(resolve_target),
		.fetch_pc(fetch_pc)
	);

endmodule

// File: bench/bpred_model.svh
/* Reference model of the BTB, the direction counters and the fetch PC
   Resolves train the tables before the lookup, so same-cycle updates are seen */
`ifndef BPRED_MODEL_SVH
`define BPRED_MODEL_SVH

bit m_valid [btb_rows];
logic [btb_tag_bits-1:0] m_tag [btb_rows];
logic [btb_target_bits-1:0] m_tgt [btb_rows];	// Target bits 13 to 2
int m_ctr [bht_rows];				// Counter value 0 to 3
logic [31:0] m_pc;				// Expected fetch PC

task automatic model_reset();
	for (int i = 0; i < btb_rows; i++) begin
		m_valid[i] = 1'b0;
	end
	for (int i = 0; i < bht_rows; i++) begin
		m_ctr[i] = ctr_reset;	// Weakly not taken
	end
	m_pc = reset_pc;
endtask

// Counter step and BTB allocate for one resolved branch
task automatic model_train(input bit rv, input logic [31:0] rpc, input bit rt,
		input logic [31:0] rtarget);
	pc_word_u w;
	int row;
	w.word = rpc;
	row = rpc[7:2];
	if (rv) begin
		if (rt)
			m_ctr[row] = (m_ctr[row] < 3) ? m_ctr[row] + 1 : 3;
		else
			m_ctr[row] = (m_ctr[row] > 0) ? m_ctr[row] - 1 : 0;
		if (rt) begin
			m_valid[w.f.index] = 1'b1;	// Overwrites any alias
			m_tag[w.f.index] = w.f.tag;
			m_tgt[w.f.index] = rtarget[13:2];
		end
	end
endtask

function automatic bit model_hit(input logic [31:0] pc, input bit is_br);
	pc_word_u w;
	w.word = pc;
	return is_br && m_valid[w.f.index] && (m_tag[w.f.index] == w.f.tag);
endfunction

// Upper bits from the fetch PC, stored bits in the middle
function automatic logic [31:0] model_target(input logic [31:0] pc);
	pc_word_u w;
	w.word = pc;
	return {pc[31:14], m_tgt[w.f.index], 2'b00};
endfunction

function automatic bit model_taken(input logic [31:0] pc);
	return m_ctr[pc[7:2]] >= 2;
endfunction

// Next fetch PC: redirect, then stall, then prediction, then sequential
task automatic model_advance(input bit ready, input bit redirect, input logic [31:0] rpc,
		input bit rt, input logic [31:0] rtarget, input bit ptaken,
		input logic [31:0] ptarget);
	if (redirect)
		m_pc = rt ? rtarget : rpc + 32'd4;
	else if (ready && ptaken)
		m_pc = ptarget;
	else if (ready)
		m_pc = m_pc + 32'd4;
endtask

`endif

// File: bench/bpred_tb.sv
/* Testbench for the fetch-side branch predictor
   Directed and seeded random resolves and stalls, checked against a model every cycle */
`timescale 1ns/1ps

module bpred_tb;

	import bpred_pkg::*;

	logic clock;
	logic reset;
	logic fetch_ready;
	logic fetch_is_branch;
	logic resolve_valid;
	logic [31:0] resolve_pc;
	logic resolve_taken;
	logic [31:0] resolve_target;
	logic resolve_mispredict;
	logic [31:0] fetch_pc;
	logic predict_taken;
	logic [31:0] predict_target;

	logic [31:0] pool [24];		// Branch addresses that partly alias in the BTB
	int errors;
	int checks;
	bit seen_taken;			// Some taken branch was resolved
	int unsigned seed;

	`include "bpred_model.svh"

	branch_predictor dut_i (
		.clock(clock),
		.reset(reset),
		.fetch_ready(fetch_ready),
		.fetch_is_branch(fetch_is_branch),
		.resolve_valid(resolve_valid),
		.resolve_pc(resolve_pc),
		.resolve_taken(resolve_taken),
		.resolve_target(resolve_target),
		.resolve_mispredict(resolve_mispredict),
		.fetch_pc(fetch_pc),
		.predict_taken(predict_taken),
		.predict_target(predict_target)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;	// 8 ns period
	end

	// Whole-run limit
	initial begin
		#100000;
		$display("Simulation ran past its time limit");
		$display("Test failed");
		$finish;
	end

	// Waits for the next clock edge of the given level within a few edges
	task automatic wait_edge(input logic level);
		int guard;
		guard = 0;
		@(clock);
		while (clock !== level && guard < 3) begin
			@(clock);
			guard++;
		end
		if (clock !== level) begin
			$display("Timed out waiting for a clock edge at %0t", $time);
			$display("Test failed");
			$finish;
		end
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
		errors++;
	endtask

	function automatic bit in_pool(input logic [31:0] pc);
		foreach (pool[i]) begin
			if (pool[i] == pc)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// Drives one fetch cycle at the fall and checks the prediction and the next PC
	task automatic run_cycle(input bit ready, input bit rv, input logic [31:0] rpc,
			input bit rt, input logic [31:0] rtarget, input bit rmis);
		bit is_br;
		bit exp_hit;
		bit exp_taken;
		logic [31:0] exp_target;
		wait_edge(1'b0);
		is_br = in_pool(m_pc);		// Decode flag for the fetched word
		reset = 1'b0;
		fetch_ready = ready;
		fetch_is_branch = is_br;
		resolve_valid = rv;
		resolve_pc = rpc;
		resolve_taken = rt;
		resolve_target = rtarget;
		resolve_mispredict = rmis;
		model_train(rv, rpc, rt, rtarget);	// Bypass into this lookup
		if (rv && rt)
			seen_taken = 1'b1;
		exp_hit = model_hit(m_pc, is_br);
		exp_taken = exp_hit && model_taken(m_pc);
		exp_target = model_target(m_pc);
		#2;
		checks++;
		if (predict_taken !== exp_taken)
			report_mismatch("predict_taken", predict_taken, exp_taken);
		if (!seen_taken && predict_taken !== 1'b0)
			$display("Prediction made at %0t before any taken branch resolved", $time);
		if (!seen_taken && predict_taken !== 1'b0)
			errors++;
		if (exp_hit && predict_target !== exp_target)
			report_mismatch("predict_target", predict_target, exp_target);
		model_advance(ready, rv && rmis, rpc, rt, rtarget, exp_taken, exp_target);
		wait_edge(1'b1);
		#1;
		checks++;
		if (fetch_pc !== m_pc)
			report_mismatch("fetch_pc", fetch_pc, m_pc);
	endtask

	initial begin
		bit ready;
		bit rv;
		bit rt;
		bit rmis;
		logic [31:0] rpc;
		logic [31:0] rtarget;
		errors = 0;
		checks = 0;
		seen_taken = 1'b0;
		reset = 1'b1;
		fetch_ready = 1'b0;
		fetch_is_branch = 1'b0;
		resolve_valid = 1'b0;
		resolve_pc = '0;
		resolve_taken = 1'b0;
		resolve_target = '0;
		resolve_mispredict = 1'b0;
		seed = 32'h398c2bd6;
		void'($urandom(seed));
		for (int i = 0; i < 16; i++) begin
			pool[i] = 32'h0000_1000 + 4 * i;	// One per BTB index
		end
		for (int i = 0; i < 8; i++) begin
			pool[16 + i] = 32'h0001_5400 + 8 * i;	// Aliases the low group higher up
		end

		repeat (8) wait_edge(1'b1);
		#1;
		checks++;
		if (fetch_pc !== reset_pc)
			report_mismatch("fetch_pc", fetch_pc, reset_pc);
		model_reset();

		// Sequential fetch with stalls
		repeat (3) run_cycle(1, 0, 32'h0, 0, 32'h0, 0);
		repeat (2) run_cycle(0, 0, 32'h0, 0, 32'h0, 0);
		run_cycle(1, 0, 32'h0, 0, 32'h0, 0);
		// Not-taken then taken redirect during a stall
		run_cycle(0, 1, 32'h1100, 0, 32'h0, 1);
		run_cycle(0, 1, 32'h1100, 1, 32'h1010, 1);
		// Same-cycle bypass and counter hysteresis while held at 0x1010
		run_cycle(0, 1, 32'h1010, 1, 32'h1034, 0);
		run_cycle(0, 1, 32'h1010, 1, 32'h1034, 0);
		run_cycle(0, 1, 32'h1010, 0, 32'h0, 0);
		run_cycle(0, 1, 32'h1010, 0, 32'h0, 0);
		run_cycle(0, 1, 32'h1010, 1, 32'h1034, 0);
		// Redirect beats the prediction and the alias at 0x15410 misses
		run_cycle(1, 1, 32'h1100, 1, 32'h0001_5410, 1);
		run_cycle(0, 0, 32'h0, 0, 32'h0, 0);
		run_cycle(1, 0, 32'h0, 0, 32'h0, 0);
		// Predicted jump from 0x1010 to 0x1034
		run_cycle(1, 1, 32'h1100, 1, 32'h1010, 1);
		repeat (3) run_cycle(1, 0, 32'h0, 0, 32'h0, 0);
		// Hit at a high fetch PC keeps its own upper bits
		run_cycle(1, 1, 32'h1100, 1, 32'h0001_5410, 1);
		run_cycle(0, 1, 32'h0001_5410, 1, 32'h1034, 0);
		run_cycle(1, 0, 32'h0, 0, 32'h0, 0);

		// Random resolves over the pool
		repeat (2000) begin
			ready = ($urandom % 100) < 85;
			rv = ($urandom % 2) == 0;
			rt = ($urandom % 100) < 60;
			rmis = ($urandom % 100) < 20;
			rpc = pool[$urandom % 24];
			rtarget = pool[$urandom % 24];
			run_cycle(ready, rv, rpc, rt, rtarget, rmis);
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+bench
logic/bpred_pkg.sv
logic/btb.sv
logic/bht.sv
logic/fetch_pc_gen.sv
logic/branch_predictor.sv
bench/bpred_tb.sv
